/* hw/coreDefs.sv */
package coreDefs;

	// Byte width shared by instructions, data and the accumulator
	localparam int dataWidth = 8;
	// Operand field, also the program counter and data address width
	localparam int immWidth = 4;

	// Instruction memory, core 0 in the low half, core 1 in the high half
	localparam int imemDepth = 32;
	localparam int imemAddrWidth = $clog2(imemDepth);

	// Data memory shared by both cores
	localparam int dmemDepth = 16;
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	// Upper nibble of the instruction byte
	// Codes 4'hA to 4'hE are undefined and run as NOP
	typedef enum logic [3:0] {
		NOP  = 4'h0,
		LDI  = 4'h1,
		LDM  = 4'h2,
		STM  = 4'h3,
		ADD  = 4'h4,
		SUB  = 4'h5,
		AND  = 4'h6,
		XOR  = 4'h7,
		JMP  = 4'h8,
		JZ   = 4'h9,
		HALT = 4'hF
	} opcodeT;

	// Per-core sequencing
	typedef enum logic [2:0] {
		FETCH,
		WAITINS,
		DECODE,
		DATAREQ,
		WAITDATA,
		EXECUTE,
		WRITEBACK
	} coreStateT;

endpackage

/* hw/insDecoder.sv */
`timescale 1ns/1ps

module insDecoder (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      decodeEn,
	input  logic [coreDefs::dataWidth-1:0] insWord,
	output coreDefs::opcodeT          opcode,
	output logic [coreDefs::immWidth-1:0] operand,
	output logic                      usesMem,
	output logic                      isStore,
	output logic                      isBranch
);

	import coreDefs::*;

	opcodeT rawOp;
	opcodeT validOp;

	// Opcode field sits in the upper nibble
	assign rawOp = opcodeT'(insWord[dataWidth-1 -: 4]);

	// Anything not in the table falls back to NOP
	always_comb begin
		case (rawOp)
			NOP, LDI, LDM, STM, ADD, SUB, AND, XOR, JMP, JZ, HALT:
				validOp = rawOp;
			default:
				validOp = NOP;
		endcase
	end

	// Fields held until the next fetched instruction
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opcode   <= NOP;
			operand  <= '0;
			usesMem  <= 1'b0;
			isStore  <= 1'b0;
			isBranch <= 1'b0;
		end else if (decodeEn) begin
			opcode   <= validOp;
			operand  <= insWord[immWidth-1:0];
			// Loads, stores and the four ALU ops touch data memory
			usesMem  <= validOp inside {LDM, STM, ADD, SUB, AND, XOR};
			isStore  <= (validOp == STM);
			isBranch <= validOp inside {JMP, JZ};
		end
	end

endmodule

/* hw/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           execEn,
	input  coreDefs::opcodeT               opcode,
	input  logic [coreDefs::immWidth-1:0]  operand,
	input  logic [coreDefs::dataWidth-1:0] acc,
	input  logic [coreDefs::dataWidth-1:0] memByte,
	output logic [coreDefs::dataWidth-1:0] result,
	output logic                           resultZero
);

	import coreDefs::*;

	logic [dataWidth-1:0] nextAcc;

	// New accumulator value, all arithmetic wraps at 8 bits
	always_comb begin
		case (opcode)
			// Immediate is zero extended
			LDI: nextAcc = {{(dataWidth-immWidth){1'b0}}, operand};
			LDM: nextAcc = memByte;
			ADD: nextAcc = acc + memByte;
			SUB: nextAcc = acc - memByte;
			AND: nextAcc = acc & memByte;
			XOR: nextAcc = acc ^ memByte;
			// Other ops leave the accumulator alone
			default: nextAcc = acc;
		endcase
	end

	// Zero condition computed here so writeback only selects it
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result     <= '0;
			resultZero <= 1'b0;
		end else if (execEn) begin
			result     <= nextAcc;
			resultZero <= (nextAcc == '0);
		end
	end

endmodule

/* hw/resultWriter.sv */
`timescale 1ns/1ps

module resultWriter (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           start,
	input  logic                           writeEn,
	input  coreDefs::opcodeT               opcode,
	input  logic [coreDefs::immWidth-1:0]  operand,
	input  logic [coreDefs::dataWidth-1:0] result,
	input  logic                           resultZero,
	output logic [coreDefs::dataWidth-1:0] acc,
	output logic [coreDefs::immWidth-1:0]  pc,
	output logic                           halted
);

	import coreDefs::*;

	logic zeroFlag;

	// Architectural state of one core
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acc      <= '0;
			zeroFlag <= 1'b0;
			pc       <= '0;
			// Idle core reports halted
			halted   <= 1'b1;
		end else if (start) begin
			acc      <= '0;
			zeroFlag <= 1'b0;
			pc       <= '0;
			halted   <= 1'b0;
		end else if (writeEn) begin
			case (opcode)
				// Accumulator writers also update the flag
				LDI, LDM, ADD, SUB, AND, XOR: begin
					acc      <= result;
					zeroFlag <= resultZero;
					pc       <= pc + 1'b1;
				end
				JMP: pc <= operand;
				JZ: pc <= zeroFlag ? operand : pc + 1'b1;
				// pc parks on the HALT
				HALT: halted <= 1'b1;
				// NOP and STM just step
				default: pc <= pc + 1'b1;
			endcase
		end
	end

endmodule

/* hw/procCore.sv */
`timescale 1ns/1ps

module procCore #(
	parameter int coreId = 0
) (
	input  logic                               clk,
	input  logic                               arstN,
	input  logic                               start,
	output logic                               insReq,
	output logic [coreDefs::imemAddrWidth-1:0] insAddr,
	input  logic                               insGrant,
	input  logic [coreDefs::dataWidth-1:0]     insData,
	output logic                               dataReq,
	output logic [coreDefs::dmemAddrWidth-1:0] dataAddr,
	output logic                               dataWe,
	output logic [coreDefs::dataWidth-1:0]     dataWdata,
	input  logic                               dataGrant,
	input  logic [coreDefs::dataWidth-1:0]     dataRdata,
	output logic [coreDefs::dataWidth-1:0]     acc,
	output logic                               halted
);

	import coreDefs::*;

	coreStateT state;
	opcodeT opcode;
	logic [immWidth-1:0] operand;
	logic [immWidth-1:0] pc;
	logic [dataWidth-1:0] memByte;
	logic [dataWidth-1:0] result;
	logic usesMem, isStore, isBranch;
	logic resultZero;
	logic decodeEn, execEn, writeEn;

	// Sequencer, held in FETCH with no request while halted
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= FETCH;
		end else if (start) begin
			state <= FETCH;
		end else begin
			case (state)
				FETCH:
					if (insGrant)
						state <= WAITINS;
				WAITINS:
					state <= DECODE;
				// Fields are valid here, so branch on them
				DECODE:
					state <= usesMem ? DATAREQ : EXECUTE;
				DATAREQ:
					if (dataGrant)
						state <= WAITDATA;
				WAITDATA:
					state <= EXECUTE;
				EXECUTE:
					state <= WRITEBACK;
				WRITEBACK:
					state <= FETCH;
				default:
					state <= FETCH;
			endcase
		end
	end

	// Operand byte arrives the cycle after the data grant
	always_ff @(posedge clk) begin
		if (state == WAITDATA)
			memByte <= dataRdata;
	end

	// Instruction side, region bit picks this core's half
	assign insReq  = (state == FETCH) && !halted;
	assign insAddr = {1'(coreId), pc};

	// Data side, stores write the current accumulator
	assign dataReq   = (state == DATAREQ);
	assign dataWe    = dataReq && isStore;
	assign dataAddr  = operand;
	assign dataWdata = acc;

	// Decoder captures the returned instruction byte directly
	assign decodeEn = (state == WAITINS);
	// Branches need no ALU work
	assign execEn   = (state == EXECUTE) && !isBranch;
	assign writeEn  = (state == WRITEBACK);

	insDecoder decodeStage (
		.clk      (clk),
		.arstN    (arstN),
		.decodeEn (decodeEn),
		.insWord  (insData),
		.opcode   (opcode),
		.operand  (operand),
		.usesMem  (usesMem),
		.isStore  (isStore),
		.isBranch (isBranch)
	);

	aluExecute execStage (
		.clk        (clk),
		.arstN      (arstN),
		.execEn     (execEn),
		.opcode     (opcode),
		.operand    (operand),
		.acc        (acc),
		.memByte    (memByte),
		.result     (result),
		.resultZero (resultZero)
	);

	resultWriter writeStage (
		.clk        (clk),
		.arstN      (arstN),
		.start      (start),
		.writeEn    (writeEn),
		.opcode     (opcode),
		.operand    (operand),
		.result     (result),
		.resultZero (resultZero),
		.acc        (acc),
		.pc         (pc),
		.halted     (halted)
	);

endmodule

/* hw/sharedMemory.sv */
`timescale 1ns/1ps

module sharedMemory (
	input  logic                               clk,
	input  logic                               arstN,
	input  logic                               running,
	// Instruction ports
	input  logic                               insReq0,
	input  logic [coreDefs::imemAddrWidth-1:0] insAddr0,
	output logic                               insGrant0,
	output logic [coreDefs::dataWidth-1:0]     insData0,
	input  logic                               insReq1,
	input  logic [coreDefs::imemAddrWidth-1:0] insAddr1,
	output logic                               insGrant1,
	output logic [coreDefs::dataWidth-1:0]     insData1,
	// Data ports
	input  logic                               dataReq0,
	input  logic [coreDefs::dmemAddrWidth-1:0] dataAddr0,
	input  logic                               dataWe0,
	input  logic [coreDefs::dataWidth-1:0]     dataWdata0,
	output logic                               dataGrant0,
	output logic [coreDefs::dataWidth-1:0]     dataRdata0,
	input  logic                               dataReq1,
	input  logic [coreDefs::dmemAddrWidth-1:0] dataAddr1,
	input  logic                               dataWe1,
	input  logic [coreDefs::dataWidth-1:0]     dataWdata1,
	output logic                               dataGrant1,
	output logic [coreDefs::dataWidth-1:0]     dataRdata1,
	// Load and peek
	input  logic                               loadEn,
	input  logic                               loadSel,
	input  logic [coreDefs::imemAddrWidth-1:0] loadAddr,
	input  logic [coreDefs::dataWidth-1:0]     loadData,
	input  logic [coreDefs::dmemAddrWidth-1:0] peekAddr,
	output logic [coreDefs::dataWidth-1:0]     peekData
);

	import coreDefs::*;

	logic [dataWidth-1:0] imem [imemDepth];
	logic [dataWidth-1:0] dmem [dmemDepth];
	logic [1:0] insGrant, dataGrant;
	// Last core served, 1 means core 1
	logic insLast, dataLast;
	logic loadOk;

	// Two-way round robin, the core not served last wins a tie
	function automatic logic [1:0] rrGrant(input logic [1:0] req, input logic lastOne);
		logic [1:0] grant;
		grant[0] = req[0] && (!req[1] || lastOne);
		grant[1] = req[1] && (!req[0] || !lastOne);
		return grant;
	endfunction

	assign insGrant  = rrGrant({insReq1, insReq0}, insLast);
	assign dataGrant = rrGrant({dataReq1, dataReq0}, dataLast);

	assign insGrant0  = insGrant[0];
	assign insGrant1  = insGrant[1];
	assign dataGrant0 = dataGrant[0];
	assign dataGrant1 = dataGrant[1];

	// Starts at core 1 so core 0 takes the first conflict
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			insLast  <= 1'b1;
			dataLast <= 1'b1;
		end else begin
			if (|insGrant)
				insLast <= insGrant[1];
			if (|dataGrant)
				dataLast <= dataGrant[1];
		end
	end

	// Loader locked out while any core runs
	assign loadOk = loadEn && !running;

	// Instruction array, read byte valid the cycle after grant
	always_ff @(posedge clk) begin
		if (loadOk && !loadSel)
			imem[loadAddr] <= loadData;
		if (insGrant[0])
			insData0 <= imem[insAddr0];
		if (insGrant[1])
			insData1 <= imem[insAddr1];
	end

	// Data array, at most one core granted per cycle
	always_ff @(posedge clk) begin
		if (loadOk && loadSel)
			dmem[loadAddr[dmemAddrWidth-1:0]] <= loadData;
		else if (dataGrant[0] && dataWe0)
			dmem[dataAddr0] <= dataWdata0;
		else if (dataGrant[1] && dataWe1)
			dmem[dataAddr1] <= dataWdata1;
		if (dataGrant[0])
			dataRdata0 <= dmem[dataAddr0];
		if (dataGrant[1])
			dataRdata1 <= dmem[dataAddr1];
	end

	// Debug read, no arbitration
	assign peekData = dmem[peekAddr];

endmodule

/* hw/dualCoreTop.sv */
`timescale 1ns/1ps

module dualCoreTop (
	input  logic                               clk,
	input  logic                               arstN,
	input  logic                               start,
	input  logic                               loadEn,
	input  logic                               loadSel,
	input  logic [coreDefs::imemAddrWidth-1:0] loadAddr,
	input  logic [coreDefs::dataWidth-1:0]     loadData,
	input  logic [coreDefs::dmemAddrWidth-1:0] peekAddr,
	output logic [coreDefs::dataWidth-1:0]     peekData,
	output logic [1:0]                         halted,
	output logic [coreDefs::dataWidth-1:0]     accOut0,
	output logic [coreDefs::dataWidth-1:0]     accOut1
);

	import coreDefs::*;

	logic [1:0] insReq, insGrant, dataReq, dataWe, dataGrant;
	logic [imemAddrWidth-1:0] insAddr [2];
	logic [dmemAddrWidth-1:0] dataAddr [2];
	logic [dataWidth-1:0] insData [2];
	logic [dataWidth-1:0] dataWdata [2];
	logic [dataWidth-1:0] dataRdata [2];
	logic [dataWidth-1:0] acc [2];
	logic running;

	// Busy until both cores have halted
	assign running = !(&halted);

	assign accOut0 = acc[0];
	assign accOut1 = acc[1];

	// Core 0 runs from the low half of instruction memory, core 1 the high
	for (genvar i = 0; i < 2; i++) begin : genCore
		procCore #(
			.coreId (i)
		) core (
			.clk       (clk),
			.arstN     (arstN),
			.start     (start),
			.insReq    (insReq[i]),
			.insAddr   (insAddr[i]),
			.insGrant  (insGrant[i]),
			.insData   (insData[i]),
			.dataReq   (dataReq[i]),
			.dataAddr  (dataAddr[i]),
			.dataWe    (dataWe[i]),
			.dataWdata (dataWdata[i]),
			.dataGrant (dataGrant[i]),
			.dataRdata (dataRdata[i]),
			.acc       (acc[i]),
			.halted    (halted[i])
		);
	end

	sharedMemory memory (
		.clk        (clk),
		.arstN      (arstN),
		.running    (running),
		.insReq0    (insReq[0]),
		.insAddr0   (insAddr[0]),
		.insGrant0  (insGrant[0]),
		.insData0   (insData[0]),
		.insReq1    (insReq[1]),
		.insAddr1   (insAddr[1]),
		.insGrant1  (insGrant[1]),
		.insData1   (insData[1]),
		.dataReq0   (dataReq[0]),
		.dataAddr0  (dataAddr[0]),
		.dataWe0    (dataWe[0]),
		.dataWdata0 (dataWdata[0]),
		.dataGrant0 (dataGrant[0]),
		.dataRdata0 (dataRdata[0]),
		.dataReq1   (dataReq[1]),
		.dataAddr1  (dataAddr[1]),
		.dataWe1    (dataWe[1]),
		.dataWdata1 (dataWdata[1]),
		.dataGrant1 (dataGrant[1]),
		.dataRdata1 (dataRdata[1]),
		.loadEn     (loadEn),
		.loadSel    (loadSel),
		.loadAddr   (loadAddr),
		.loadData   (loadData),
		.peekAddr   (peekAddr),
		.peekData   (peekData)
	);

endmodule

/* verif/tbChecker.sv */
`timescale 1ns/1ps

module tbChecker (
	input  logic                               clk,
	input  logic [coreDefs::dmemAddrWidth-1:0] peekAddr,
	input  logic [coreDefs::dataWidth-1:0]     peekData,
	input  logic [coreDefs::dataWidth-1:0]     accOut0,
	input  logic [coreDefs::dataWidth-1:0]     accOut1,
	input  logic                               checkEn,
	input  logic [1:0]                         checkKind,
	input  logic [coreDefs::dataWidth-1:0]     expected,
	input  logic                               testDone,
	input  logic                               reportEn,
	input  int                                 testId,
	output int                                 failedTests,
	output int                                 checksRun
);

	import coreDefs::*;

	logic [dataWidth-1:0] seen;
	int checkCount = 0;
	int mismatchCount = 0;
	int testMismatches = 0;
	int passCount = 0;
	int failCount = 0;

	// A test still open with mismatches also counts as failed
	assign failedTests = failCount + ((testMismatches != 0) ? 1 : 0);
	assign checksRun = checkCount;

	// Value under comparison
	always_comb begin
		case (checkKind)
			2'd1: seen = accOut0;
			2'd2: seen = accOut1;
			default: seen = peekData;
		endcase
	end

	// Label for error lines
	function automatic string targetName(input logic [1:0] kind,
		input logic [dmemAddrWidth-1:0] addr);
		if (kind == 2'd1)
			return "accumulator of core 0";
		else if (kind == 2'd2)
			return "accumulator of core 1";
		return $sformatf("data byte %0d", addr);
	endfunction

	// Samples on the falling edge half a cycle after the drive
	always @(negedge clk) begin
		if (checkEn) begin
			checkCount++;
			// X or Z counts as wrong
			if (seen !== expected) begin
				$display("MISMATCH at %0d ns: test %0d, %s expected %h, seen %h",
					$time, testId, targetName(checkKind, peekAddr), expected, seen);
				mismatchCount++;
				testMismatches++;
			end
		end
		if (testDone) begin
			if (testMismatches == 0) begin
				$display("Test %0d passed", testId);
				passCount++;
			end else begin
				$display("Test %0d failed with %0d mismatches", testId, testMismatches);
				failCount++;
			end
			testMismatches = 0;
		end
		if (reportEn)
			$display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d",
				passCount, failCount, checkCount, mismatchCount);
	end

endmodule

/* verif/tbTop.sv */
`timescale 1ns/1ps

module tbTop;

	import coreDefs::*;

	localparam int maxRecords = 256;
	// Cycles allowed for one program run
	localparam int haltTimeout = 2000;

	logic clk;
	logic arstN;
	logic start;
	logic loadEn;
	logic loadSel;
	logic [imemAddrWidth-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic [dmemAddrWidth-1:0] peekAddr;
	logic [dataWidth-1:0] peekData;
	logic [1:0] halted;
	logic [dataWidth-1:0] accOut0;
	logic [dataWidth-1:0] accOut1;

	// Strobes into the checker
	logic checkEn;
	logic [1:0] checkKind;
	logic [dataWidth-1:0] expected;
	logic testDone;
	logic reportEn;
	int testId;
	int failedTests;
	int checksRun;

	// Kind nibble, address byte, data byte
	logic [19:0] records [maxRecords];
	logic hung;
	logic badRecord;

	// 4 ns period
	always #2 clk = ~clk;

	dualCoreTop uut (
		.clk      (clk),
		.arstN    (arstN),
		.start    (start),
		.loadEn   (loadEn),
		.loadSel  (loadSel),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.peekAddr (peekAddr),
		.peekData (peekData),
		.halted   (halted),
		.accOut0  (accOut0),
		.accOut1  (accOut1)
	);

	tbChecker checkUnit (
		.clk         (clk),
		.peekAddr    (peekAddr),
		.peekData    (peekData),
		.accOut0     (accOut0),
		.accOut1     (accOut1),
		.checkEn     (checkEn),
		.checkKind   (checkKind),
		.expected    (expected),
		.testDone    (testDone),
		.reportEn    (reportEn),
		.testId      (testId),
		.failedTests (failedTests),
		.checksRun   (checksRun)
	);

	// Lands 1 ns past the next rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// One byte through the load port, sel 1 picks data memory
	task automatic loadByte(input logic sel, input logic [imemAddrWidth-1:0] addr,
		input logic [dataWidth-1:0] data);
		loadEn = 1'b1;
		loadSel = sel;
		loadAddr = addr;
		loadData = data;
		nextCycle();
		loadEn = 1'b0;
	endtask

	// Start pulse, then poll halted with a bound
	task automatic runPrograms();
		int cycles;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		cycles = 0;
		// halted already dropped on the start edge
		while (halted != 2'b11 && cycles < haltTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (halted != 2'b11) begin
			$display("Core never halted in test %0d after %0d cycles, halted = %b",
				testId, haltTimeout, halted);
			hung = 1'b1;
		end
		nextCycle();
	endtask

	// kind 0 peeks data memory, 1 and 2 pick an accumulator
	task automatic checkValue(input logic [1:0] kind, input logic [dmemAddrWidth-1:0] addr,
		input logic [dataWidth-1:0] value);
		checkEn = 1'b1;
		checkKind = kind;
		peekAddr = addr;
		expected = value;
		nextCycle();
		checkEn = 1'b0;
	endtask

	task automatic closeTest();
		testDone = 1'b1;
		nextCycle();
		testDone = 1'b0;
		testId++;
	endtask

	initial begin
		int idx;
		logic [19:0] rec;
		clk = 1'b0;
		arstN = 1'b0;
		start = 1'b0;
		loadEn = 1'b0;
		loadSel = 1'b0;
		loadAddr = '0;
		loadData = '0;
		peekAddr = '0;
		checkEn = 1'b0;
		checkKind = 2'd0;
		expected = '0;
		testDone = 1'b0;
		reportEn = 1'b0;
		testId = 1;
		hung = 1'b0;
		badRecord = 1'b0;
		// Unread entries act as end of file
		for (idx = 0; idx < maxRecords; idx++)
			records[idx] = 20'hF0000;
		$readmemh("verif/coreTests.dat", records);
		repeat (8) @(posedge clk);
		#1;
		arstN = 1'b1;
		nextCycle();
		idx = 0;
		while (idx < maxRecords && !hung && !badRecord && records[idx][19:16] != 4'hF) begin
			rec = records[idx];
			case (rec[19:16])
				4'h1: loadByte(1'b0, rec[12:8], rec[7:0]);
				4'h2: loadByte(1'b1, rec[12:8], rec[7:0]);
				4'h3: runPrograms();
				4'h4: checkValue(2'd0, rec[11:8], rec[7:0]);
				4'h5: checkValue(2'd1, rec[11:8], rec[7:0]);
				4'h6: checkValue(2'd2, rec[11:8], rec[7:0]);
				4'h7: closeTest();
				default: begin
					$display("Unknown record %h at entry %0d of the test file", rec, idx);
					badRecord = 1'b1;
				end
			endcase
			idx++;
		end
		// Counts line comes from the checker
		reportEn = 1'b1;
		nextCycle();
		reportEn = 1'b0;
		if (checksRun == 0)
			$display("No checks ran, the test file is missing or empty");
		if (hung || badRecord || failedTests != 0 || checksRun == 0) begin
			$display("*** TEST FAILED ***");
		end else begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	end

endmodule

/* verif/coreTests.dat */
// Each record is kind, address (two digits), data (two digits)
// Kind 1 imem, 2 dmem, 3 run, 4 expect dmem, 5 acc0, 6 acc1, 7 end test, F end
// Test 1, core 0 ALU ops with a wrap past 255, core 1 halts at once
10015 10140 10241 10338 10452 10563 10673 10739 108F0 110F0
200C8 20164 2020F 2035A 208EE 209EE
30000 40831 40958 50058 60000 70000
// Test 2, LDM and STM move bytes around
10024 1013A 10225 1033B 1042A 1053C 106F0 110F0
204A7 2053C 20AEE 20BEE 20CEE
30000 40AA7 40B3C 40CA7 404A7 4053C 500A7 60000 70000
// Test 3, JZ taken then not taken, JMP skips a store
10010 10194 10236 103F0 10413 10598 10637 10789 1083D 10919 10A3E 10BF0 110F0
206EE 207EE 20DEE 20EEE
30000 406EE 40703 40DEE 40E09 50009 60000 70000
// Test 4, both cores on disjoint data bytes
10020 10141 10232 10370 10433 105F0
11028 11159 1123A 11368 1143B 115F0
20012 20134 20890 20925 202EE 203EE 20AEE 20BEE
30000 40246 40354 40A6B 40B00 50054 60000 70000
// Test 5, undefined opcodes act as NOP, core 0 ends with zero flag set
10017 101A3 102BF 103C0 104D5 1053F 106E9 10710 108F0
11016 111E2 112F0
20FEE
30000 40F07 50000 60006 70000
// Test 6, restart clears flag and accumulators, leading JZ falls through
10093 10112 10236 103F0
11041 11137 112F0
206EE 207EE 20121
30000 40602 40721 50002 60021 70000
F0000

/* flist.f */
hw/coreDefs.sv
hw/insDecoder.sv
hw/aluExecute.sv
hw/resultWriter.sv
hw/procCore.sv
hw/sharedMemory.sv
hw/dualCoreTop.sv
verif/tbChecker.sv
verif/tbTop.sv

/* run.sh */
#!/bin/sh
# Build and run the dual-core testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tbTop -Mdir "$buildDir" -o simTop
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simTop" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" "$logFile"; then
	exit 0
fi
exit 1
